/* source/ecdsa_pkg.sv */
// Shared widths, register map, bridge states and reset values for the ECDSA key-lifetime subsystem.
package ecdsa_pkg;

	// PIO and AXI4-Lite data width.
	localparam int pio_nbits = 32;

	// Byte address width on both the AXI side and the PIO bus.
	localparam int pio_addr_nbits = 8;

	// Width of the expiry time and of the lifetime countdown.
	localparam int real_time_nbits = 24;

	// The default expiry time comes out of reset as the longest possible lifetime.
	localparam logic [real_time_nbits-1:0] default_exp_time_reset = {real_time_nbits{1'b1}};

	// AXI response codes that the bridge can return.
	localparam logic [1:0] axi_resp_okay = 2'b00;
	localparam logic [1:0] axi_resp_slverr = 2'b10;

	// Word addresses of the register block.
	typedef enum logic [pio_addr_nbits-1:0] {
		DEFAULT_EXP_TIME = 8'h00, // Read/write, lifetime given to each newly loaded key.
		KEY_LOAD = 8'h04, // Write-only, any write starts a new key lifetime.
		KEY_STATUS = 8'h08 // Read-only, bit 24 expired and bits 23..0 remaining time.
	} ecdsa_reg_addr_e;

	// States of the AXI4-Lite to PIO bridge.
	typedef enum logic [2:0] {
		IDLE, // Waiting for an AXI request.
		WRITE, // PIO write issued, waiting for the ack.
		READ, // PIO read issued, waiting for the ack.
		WRESP, // Holding bvalid until the master takes it.
		RRESP // Holding rvalid until the master takes it.
	} bridge_state_e;

endpackage

/* source/pio_if.sv */
// PIO register bus between the AXI4-Lite bridge and the ECDSA register block.
`timescale 1ns/1ns

interface pio_if;

	// Request side, owned by the bridge.
	logic reg_bs; // Bus select, held from the strobe until the ack.
	logic reg_rd; // One-cycle read strobe.
	logic reg_wr; // One-cycle write strobe.
	logic [ecdsa_pkg::pio_addr_nbits-1:0] reg_addr; // Held until the ack.
	logic [ecdsa_pkg::pio_nbits-1:0] reg_din; // Write data, held until the ack.

	// Response side, owned by the register block.
	logic pio_ack; // One-cycle completion pulse, paced by clk_div.
	logic pio_rvalid; // High with the ack when the address decoded.
	logic [ecdsa_pkg::pio_nbits-1:0] pio_rdata; // Read data, valid with pio_rvalid.

	modport bridge (
		output reg_bs, reg_rd, reg_wr, reg_addr, reg_din,
		input pio_ack, pio_rvalid, pio_rdata
	);

	// The register block side (reg itself is a keyword).
	modport regs (
		input reg_bs, reg_rd, reg_wr, reg_addr, reg_din,
		output pio_ack, pio_rvalid, pio_rdata
	);

endinterface

/* source/pio_axil_bridge.sv */
// AXI4-Lite slave that turns one host access at a time into a PIO register bus transaction.
`timescale 1ns/1ns

module pio_axil_bridge (
	input logic clk,
	input logic reset,

	input logic awvalid,
	output logic awready,
	input logic [ecdsa_pkg::pio_addr_nbits-1:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [ecdsa_pkg::pio_nbits-1:0] wdata,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,

	input logic arvalid,
	output logic arready,
	input logic [ecdsa_pkg::pio_addr_nbits-1:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [ecdsa_pkg::pio_nbits-1:0] rdata,
	output logic [1:0] rresp,

	pio_if.bridge pio
);

	ecdsa_pkg::bridge_state_e state;

	logic aw_take; // AW and W complete together in this cycle.
	logic ar_take; // AR completes in this cycle.

	assign aw_take = awready & awvalid & wvalid;
	assign ar_take = arready & arvalid;

	// Control path. Readies are only raised in IDLE, so a held response stalls new requests.
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ecdsa_pkg::IDLE;
			awready <= 1'b0;
			wready <= 1'b0;
			arready <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			pio.reg_bs <= 1'b0;
			pio.reg_rd <= 1'b0;
			pio.reg_wr <= 1'b0;
		end else begin
			case (state)
				ecdsa_pkg::IDLE: begin
					if (aw_take) begin
						awready <= 1'b0;
						wready <= 1'b0;
						pio.reg_bs <= 1'b1; // Request goes out the cycle after acceptance.
						pio.reg_wr <= 1'b1;
						state <= ecdsa_pkg::WRITE;
					end else if (ar_take) begin
						arready <= 1'b0;
						pio.reg_bs <= 1'b1;
						pio.reg_rd <= 1'b1;
						state <= ecdsa_pkg::READ;
					end else if (awvalid && wvalid && !arready) begin
						awready <= 1'b1; // Writes win when both arrive together.
						wready <= 1'b1;
					end else if (arvalid && !awready) begin
						arready <= 1'b1;
					end
				end
				ecdsa_pkg::WRITE: begin
					pio.reg_wr <= 1'b0; // Strobe lasts one cycle, select stays up.
					if (pio.pio_ack) begin
						pio.reg_bs <= 1'b0;
						bvalid <= 1'b1;
						state <= ecdsa_pkg::WRESP;
					end
				end
				ecdsa_pkg::READ: begin
					pio.reg_rd <= 1'b0;
					if (pio.pio_ack) begin
						pio.reg_bs <= 1'b0;
						rvalid <= 1'b1;
						state <= ecdsa_pkg::RRESP;
					end
				end
				ecdsa_pkg::WRESP: begin
					if (bready) begin
						bvalid <= 1'b0;
						state <= ecdsa_pkg::IDLE;
					end
				end
				ecdsa_pkg::RRESP: begin
					if (rready) begin
						rvalid <= 1'b0;
						state <= ecdsa_pkg::IDLE;
					end
				end
				default: state <= ecdsa_pkg::IDLE;
			endcase
		end
	end

	// Payload capture. Address and data stay put on the PIO bus until the next request.
	always_ff @(posedge clk) begin
		if (state == ecdsa_pkg::IDLE && aw_take) begin
			pio.reg_addr <= awaddr;
			pio.reg_din <= wdata; // Whole word, write strobes are not used.
		end else if (state == ecdsa_pkg::IDLE && ar_take) begin
			pio.reg_addr <= araddr;
		end
		if (state == ecdsa_pkg::WRITE && pio.pio_ack) begin
			bresp <= pio.pio_rvalid ? ecdsa_pkg::axi_resp_okay : ecdsa_pkg::axi_resp_slverr;
		end
		if (state == ecdsa_pkg::READ && pio.pio_ack) begin
			rresp <= pio.pio_rvalid ? ecdsa_pkg::axi_resp_okay : ecdsa_pkg::axi_resp_slverr;
			rdata <= pio.pio_rvalid ? pio.pio_rdata : '0; // Undecoded reads return zero.
		end
	end

endmodule

/* source/rt_tick_gen.sv */
// Clock divider that gives the one-cycle clk_div real-time tick used by the key lifetime logic.
`timescale 1ns/1ns

module rt_tick_gen #(
	parameter int DIV_RATIO = 4 // Clock cycles per real-time tick.
) (
	input logic clk,
	input logic reset,
	output logic clk_div
);

	// A ratio of one still needs a one-bit counter.
	localparam int CNT_NBITS = (DIV_RATIO > 1) ? $clog2(DIV_RATIO) : 1;
	localparam logic [CNT_NBITS-1:0] CNT_LAST = CNT_NBITS'(DIV_RATIO - 1);

	logic [CNT_NBITS-1:0] cnt; // Position inside the current tick period.

	// The counter wraps at the end of each period and the tick is registered from the wrap,
	// so the first tick shows DIV_RATIO cycles after reset is released.
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
			clk_div <= 1'b0;
		end else if (cnt == CNT_LAST) begin
			cnt <= '0; // Wrap.
			clk_div <= 1'b1;
		end else begin
			cnt <= cnt + 1'b1;
			clk_div <= 1'b0;
		end
	end

endmodule

/* source/ecdsa_reg.sv */
// ECDSA register block on the PIO bus with the default expiry time, the key load strobe and status.
`timescale 1ns/1ns

module ecdsa_reg #(
	parameter int RT_NBITS = ecdsa_pkg::real_time_nbits
) (
	input logic clk,
	input logic reset,
	input logic clk_div, // Real-time tick that paces the acks.

	pio_if.regs pio,

	output logic [RT_NBITS-1:0] default_exp_time,
	output logic key_load, // One-cycle pulse on a KEY_LOAD write.
	input logic [RT_NBITS-1:0] remaining,
	input logic expired
);

	logic req; // A read or write request is on the bus this cycle.
	logic ack_pend; // Request seen, ack waits for the next tick.
	logic reg_rd_d1; // The pending request is a read.

	logic sel_default_exp_time;
	logic sel_key_load;
	logic rd_hit; // Address is readable.
	logic wr_hit; // Address is writable.

	assign req = pio.reg_bs & (pio.reg_rd | pio.reg_wr);

	// Address decode, also building the read word. The address is held until the ack.
	always_comb begin
		sel_default_exp_time = 1'b0;
		sel_key_load = 1'b0;
		rd_hit = 1'b0;
		wr_hit = 1'b0;
		pio.pio_rdata = '0;
		case (ecdsa_pkg::ecdsa_reg_addr_e'(pio.reg_addr))
			ecdsa_pkg::DEFAULT_EXP_TIME: begin
				sel_default_exp_time = 1'b1;
				rd_hit = 1'b1;
				wr_hit = 1'b1;
				pio.pio_rdata = {{(ecdsa_pkg::pio_nbits - RT_NBITS){1'b0}}, default_exp_time};
			end
			ecdsa_pkg::KEY_LOAD: begin
				sel_key_load = 1'b1;
				wr_hit = 1'b1; // Nothing to read back here.
			end
			ecdsa_pkg::KEY_STATUS: begin
				rd_hit = 1'b1; // Status is read-only.
				pio.pio_rdata = {{(ecdsa_pkg::pio_nbits - RT_NBITS - 1){1'b0}}, expired, remaining};
			end
			default: begin
				rd_hit = 1'b0; // Undecoded, answered with a bare ack.
			end
		endcase
	end

	// The load pulse lines up with the write strobe, so the timer sees the stored expiry time.
	assign key_load = pio.reg_bs & pio.reg_wr & sel_key_load;

	// Request tracking. The read flag is kept so the response can be qualified at the tick.
	always_ff @(posedge clk) begin
		if (reset) begin
			ack_pend <= 1'b0;
			reg_rd_d1 <= 1'b0;
			pio.pio_ack <= 1'b0;
			pio.pio_rvalid <= 1'b0;
		end else begin
			ack_pend <= req ? 1'b1 : clk_div ? 1'b0 : ack_pend;
			reg_rd_d1 <= req ? pio.reg_rd : reg_rd_d1;
			pio.pio_ack <= clk_div & ack_pend; // Single pulse at the tick.
			// On writes pio_rvalid flags a writable address so the bridge can pick the response.
			pio.pio_rvalid <= clk_div & ack_pend & (reg_rd_d1 ? rd_hit : wr_hit);
		end
	end

	// Default expiry register, written straight from the request cycle.
	always_ff @(posedge clk) begin
		if (reset) begin
			default_exp_time <= RT_NBITS'(ecdsa_pkg::default_exp_time_reset);
		end else if (pio.reg_bs && pio.reg_wr && sel_default_exp_time) begin
			default_exp_time <= pio.reg_din[RT_NBITS-1:0]; // Upper bits are dropped.
		end
	end

endmodule

/* source/key_expiry_timer.sv */
// Down-counter that tracks the loaded key's remaining lifetime in real-time ticks.
`timescale 1ns/1ns

module key_expiry_timer #(
	parameter int RT_NBITS = ecdsa_pkg::real_time_nbits
) (
	input logic clk,
	input logic reset,
	input logic clk_div, // One count per tick.
	input logic key_load, // Starts a new lifetime.
	input logic [RT_NBITS-1:0] default_exp_time,
	output logic [RT_NBITS-1:0] remaining,
	output logic expired // Sticky until the next load.
);

	logic armed; // A lifetime is running.

	// A load always restarts the count, even while a previous lifetime is still running.
	// The tick that takes remaining to zero also sets expired.
	always_ff @(posedge clk) begin
		if (reset) begin
			remaining <= '0;
			expired <= 1'b0;
			armed <= 1'b0;
		end else if (key_load) begin
			remaining <= default_exp_time;
			expired <= 1'b0;
			armed <= 1'b1;
		end else if (clk_div && armed) begin
			if (remaining > RT_NBITS'(1)) begin
				remaining <= remaining - 1'b1;
			end else begin
				remaining <= '0; // Also covers a key loaded with a zero lifetime.
				expired <= 1'b1;
				armed <= 1'b0;
			end
		end
	end

endmodule

/* source/ecdsa_subsys.sv */
// Top level of the ECDSA key-lifetime subsystem with its AXI4-Lite host port and expiry flag.
`timescale 1ns/1ns

module ecdsa_subsys #(
	parameter int DIV_RATIO = 4, // Clock cycles per real-time tick.
	parameter int RT_NBITS = ecdsa_pkg::real_time_nbits
) (
	input logic clk,
	input logic reset,

	input logic awvalid,
	output logic awready,
	input logic [ecdsa_pkg::pio_addr_nbits-1:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [ecdsa_pkg::pio_nbits-1:0] wdata,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,

	input logic arvalid,
	output logic arready,
	input logic [ecdsa_pkg::pio_addr_nbits-1:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [ecdsa_pkg::pio_nbits-1:0] rdata,
	output logic [1:0] rresp,

	output logic key_expired
);

	logic clk_div;
	logic [RT_NBITS-1:0] default_exp_time;
	logic key_load;
	logic [RT_NBITS-1:0] remaining;

	pio_if pio ();

	pio_axil_bridge pio_axil_bridge_i (
		.clk(clk), .reset(reset),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.pio(pio.bridge)
	);

	rt_tick_gen #(.DIV_RATIO(DIV_RATIO)) rt_tick_gen_i (
		.clk(clk), .reset(reset), .clk_div(clk_div)
	);

	// The timer's expired flag is both the status bit and the top-level output.
	ecdsa_reg #(.RT_NBITS(RT_NBITS)) ecdsa_reg_i (
		.clk(clk), .reset(reset), .clk_div(clk_div),
		.pio(pio.regs),
		.default_exp_time(default_exp_time), .key_load(key_load),
		.remaining(remaining), .expired(key_expired)
	);

	key_expiry_timer #(.RT_NBITS(RT_NBITS)) key_expiry_timer_i (
		.clk(clk), .reset(reset), .clk_div(clk_div),
		.key_load(key_load), .default_exp_time(default_exp_time),
		.remaining(remaining), .expired(key_expired)
	);

endmodule

/* test/tb_ecdsa_subsys.sv */
// Testbench for the ECDSA key-lifetime subsystem, driving AXI4-Lite accesses and checking status.
`timescale 1ns/1ns

module tb_ecdsa_subsys;

	localparam int div_ratio = 4; // Clock cycles per real-time tick in the DUT.
	localparam int clk_period = 8;
	localparam int num_tests = 6;
	localparam int watchdog_ns = num_tests * 200 * clk_period; // Generous bound for all tests.
	localparam int max_checks = 256;
	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	logic clk;
	logic reset;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [7:0] awaddr, araddr;
	logic [31:0] wdata, rdata;
	logic [1:0] bresp, rresp;
	logic key_expired;

	int cyc; // Clock edges since reset was released.
	int tick_cnt; // Real-time ticks seen by the DUT since reset.

	// Recorded checks, filled by the stimulus and drained by the compare process.
	logic [31:0] act_arr [max_checks];
	logic [31:0] exp_arr [max_checks];
	int tol_arr [max_checks];
	string msg_arr [max_checks];
	int n_pushed = 0;
	int n_done = 0;
	int errors = 0;

	ecdsa_subsys #(.DIV_RATIO(div_ratio)) ecdsa_subsys_i (.*);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// The divider ticks after every div_ratio edges, and the timer acts on the edge after that.
	always @(posedge clk) begin
		if (reset) begin
			cyc <= 0;
			tick_cnt <= 0;
		end else begin
			cyc <= cyc + 1;
			if (cyc != 0 && cyc % div_ratio == 0) tick_cnt <= tick_cnt + 1;
		end
	end

	// Expected KEY_STATUS word after a load of exp_time and elapsed ticks since the load.
	function automatic logic [31:0] key_status(input logic [23:0] exp_time, input int elapsed);
		logic [23:0] left;
		logic exp_flag;
		if (elapsed >= int'(exp_time) && elapsed > 0) begin
			left = '0; // The lifetime has run out.
			exp_flag = 1'b1;
		end else begin
			left = exp_time - 24'(elapsed);
			exp_flag = 1'b0;
		end
		return {7'b0, exp_flag, left};
	endfunction

	// Compares one value against its expectation, allowing a small difference where time is fuzzy.
	task automatic check_value(input logic [31:0] actual, expected, input int tol, input string msg);
		logic [31:0] diff;
		diff = (actual > expected) ? actual - expected : expected - actual;
		if (diff > 32'(tol)) begin
			errors = errors + 1;
			$display("Fail at %0t ns: %s, got 0x%08h, expected 0x%08h", $time, msg, actual, expected);
		end
	endtask

	// The compare process works through every recorded check.
	always @(posedge clk) begin
		while (n_done < n_pushed) begin
			check_value(act_arr[n_done], exp_arr[n_done], tol_arr[n_done], msg_arr[n_done]);
			n_done = n_done + 1;
		end
	end

	task automatic expect_value(input logic [31:0] actual, expected, input int tol, input string msg);
		act_arr[n_pushed] = actual;
		exp_arr[n_pushed] = expected;
		tol_arr[n_pushed] = tol;
		msg_arr[n_pushed] = msg;
		n_pushed = n_pushed + 1;
	endtask

	// Inputs change 1 ns after the rising edge.
	task automatic next_cycle;
		@(posedge clk);
		#1;
	endtask

	// Handshakes are judged at the falling edge, where the DUT outputs are settled.
	task automatic aw_phase(input logic [7:0] addr, input logic [31:0] data);
		logic hs;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		hs = 1'b0;
		while (!hs) begin
			@(negedge clk);
			hs = awready & wready; // AW and W are taken together.
			next_cycle();
		end
		awvalid = 1'b0;
		wvalid = 1'b0;
	endtask

	task automatic b_phase(output logic [1:0] resp);
		logic hs;
		int delay;
		delay = $urandom_range(0, 12); // Late bready holds bvalid up.
		hs = 1'b0;
		while (!hs) begin
			if (delay == 0) bready = 1'b1;
			@(negedge clk);
			hs = bvalid & bready;
			resp = bresp;
			next_cycle();
			if (delay > 0) delay = delay - 1;
		end
		bready = 1'b0;
	endtask

	task automatic ar_phase(input logic [7:0] addr);
		logic hs;
		araddr = addr;
		arvalid = 1'b1;
		hs = 1'b0;
		while (!hs) begin
			@(negedge clk);
			hs = arready;
			next_cycle();
		end
		arvalid = 1'b0;
	endtask

	// Also reports the tick count when rvalid first showed, which dates the read data.
	task automatic r_phase(output logic [31:0] data, output logic [1:0] resp, output int at_tick);
		logic hs;
		logic seen;
		int delay;
		delay = $urandom_range(0, 12);
		hs = 1'b0;
		seen = 1'b0;
		at_tick = 0;
		while (!hs) begin
			if (delay == 0) rready = 1'b1;
			@(negedge clk);
			if (rvalid && !seen) begin
				seen = 1'b1;
				at_tick = tick_cnt;
			end
			hs = rvalid & rready;
			data = rdata;
			resp = rresp;
			next_cycle();
			if (delay > 0) delay = delay - 1;
		end
		rready = 1'b0;
	endtask

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data, output logic [1:0] resp);
		aw_phase(addr, data);
		b_phase(resp);
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
			output logic [1:0] resp, output int at_tick);
		ar_phase(addr);
		r_phase(data, resp, at_tick);
	endtask

	initial begin : main_seq
		logic [31:0] data;
		logic [31:0] exp_word;
		logic [1:0] resp;
		logic [23:0] exp_time;
		logic aw_early;
		int t_load;
		int t_read;
		int waited;
		int unsigned seed_val;
		seed_val = $urandom(44962);
		reset = 1'b1;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		// Reset value of the default expiry time is all ones.
		axi_read(ecdsa_pkg::DEFAULT_EXP_TIME, data, resp, t_read);
		expect_value(data, 32'h00FF_FFFF, 0, "DEFAULT_EXP_TIME after reset");
		expect_value(32'(resp), 32'(resp_okay), 0, "rresp of DEFAULT_EXP_TIME");
		expect_value(32'(key_expired), 32'd0, 0, "key_expired after reset");

		repeat (3) begin
			data = $urandom;
			exp_time = data[23:0]; // Only 24 bits are stored.
			axi_write(ecdsa_pkg::DEFAULT_EXP_TIME, data, resp);
			expect_value(32'(resp), 32'(resp_okay), 0, "bresp of DEFAULT_EXP_TIME write");
			axi_read(ecdsa_pkg::DEFAULT_EXP_TIME, data, resp, t_read);
			expect_value(data, {8'h00, exp_time}, 0, "DEFAULT_EXP_TIME read back");
		end

		axi_read(8'h0C, data, resp, t_read); // Nothing lives at 0x0C.
		expect_value(32'(resp), 32'(resp_slverr), 0, "rresp of undecoded read");
		expect_value(data, 32'd0, 0, "rdata of undecoded read");
		axi_write(8'h0C, 32'h1234_5678, resp);
		expect_value(32'(resp), 32'(resp_slverr), 0, "bresp of undecoded write");

		// Short lifetime, waited out with a bound.
		exp_time = 24'd20;
		axi_write(ecdsa_pkg::DEFAULT_EXP_TIME, {8'h00, exp_time}, resp);
		aw_phase(ecdsa_pkg::KEY_LOAD, 32'd1);
		t_load = tick_cnt;
		b_phase(resp);
		expect_value(32'(resp), 32'(resp_okay), 0, "bresp of KEY_LOAD write");
		waited = 0;
		while (!key_expired && waited < (int'(exp_time) + 2) * div_ratio) begin
			next_cycle();
			waited = waited + 1;
		end
		expect_value(32'(key_expired), 32'd1, 0, "key_expired after the lifetime");
		expect_value(32'(tick_cnt - t_load), 32'(exp_time), 1, "ticks from load to expiry");
		axi_read(ecdsa_pkg::KEY_STATUS, data, resp, t_read);
		expect_value(data, key_status(exp_time, t_read - t_load), 0, "KEY_STATUS after expiry");

		// A second load restarts the count and clears the flag.
		exp_time = 24'd60;
		axi_write(ecdsa_pkg::DEFAULT_EXP_TIME, {8'h00, exp_time}, resp);
		aw_phase(ecdsa_pkg::KEY_LOAD, 32'd0);
		t_load = tick_cnt;
		b_phase(resp);
		expect_value(32'(key_expired), 32'd0, 0, "key_expired after a second KEY_LOAD");
		repeat (10 * div_ratio) next_cycle();
		axi_read(ecdsa_pkg::KEY_STATUS, data, resp, t_read);
		exp_word = key_status(exp_time, t_read - t_load);
		expect_value(32'(data[23:0]), 32'(exp_word[23:0]), 1, "remaining time during countdown");
		expect_value(32'(data[31:24]), 32'(exp_word[31:24]), 0, "status flags during countdown");

		// Hold the read response back while a write waits on AW and W.
		ar_phase(ecdsa_pkg::DEFAULT_EXP_TIME);
		awaddr = ecdsa_pkg::DEFAULT_EXP_TIME;
		wdata = 32'h005A_5A5A;
		awvalid = 1'b1;
		wvalid = 1'b1;
		aw_early = 1'b0;
		repeat (12) begin
			@(negedge clk);
			aw_early = aw_early | awready;
			next_cycle();
		end
		expect_value(32'(rvalid), 32'd1, 0, "rvalid held while rready is low");
		expect_value(32'(aw_early), 32'd0, 0, "write accepted during a held read response");
		r_phase(data, resp, t_read);
		expect_value(data, {8'h00, exp_time}, 0, "held read data");
		aw_phase(ecdsa_pkg::DEFAULT_EXP_TIME, 32'h005A_5A5A); // Valid is still up from above.
		b_phase(resp);
		expect_value(32'(resp), 32'(resp_okay), 0, "bresp of the waiting write");
		axi_read(ecdsa_pkg::DEFAULT_EXP_TIME, data, resp, t_read);
		expect_value(data, 32'h005A_5A5A, 0, "DEFAULT_EXP_TIME after the waiting write");

		next_cycle();
		next_cycle(); // Lets the compare process catch up.
		$display("Checks: %0d, errors: %0d", n_pushed, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("Timeout: the tests did not finish within %0d ns.", watchdog_ns);
		$display("Result: FAILED");
		$finish;
	end

endmodule

/* src.f */
source/ecdsa_pkg.sv
source/pio_if.sv
source/pio_axil_bridge.sv
source/rt_tick_gen.sv
source/ecdsa_reg.sv
source/key_expiry_timer.sv
source/ecdsa_subsys.sv
test/tb_ecdsa_subsys.sv

/* run.sh */
#!/bin/bash
# Builds the testbench with Verilator, runs it and looks for the pass line in its output.
verilator --binary --timing -f src.f --top-module tb_ecdsa_subsys -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "Result: PASSED" \
	&& echo "Simulation passed." \
	|| { echo "Simulation failed or did not build." >&2; exit 1; }
